// File: design/host_mem_pkg.sv
/*
 * Host memory datapath definitions.
 * Address, page and page table index types, the translation constants
 * and the request and failure records passed between the engine,
 * the translator and the statistics recorder.
 */

package host_mem_pkg;

    // ====================
    // Geometry
    // ====================

    // Virtual and physical byte addresses share one width
    localparam int VA_WIDTH = 48;

    // 4 KB pages, so the low 12 bits pass through translation unchanged
    localparam int PAGE_BITS = 12;
    localparam int PPN_WIDTH = VA_WIDTH - PAGE_BITS;

    // Consecutive engine requests step by one cache line
    localparam int LINE_BYTES = 64;

    // The page table covers virtual pages 0 to PT_ENTRIES-1 only
    localparam int PT_ENTRIES = 16;
    localparam int PT_IDX_WIDTH = 4;

    localparam int DATA_WIDTH = 64;

    typedef logic [VA_WIDTH-1:0] va_t;
    typedef logic [VA_WIDTH-1:0] pa_t;
    typedef logic [PPN_WIDTH-1:0] ppn_t;
    // Virtual page number, the same width as a physical one
    typedef logic [PPN_WIDTH-1:0] vpn_t;
    typedef logic [PT_IDX_WIDTH-1:0] pt_idx_t;
    typedef logic [DATA_WIDTH-1:0] mem_data_t;

    // ====================
    // Records
    // ====================

    // Request on a virtual address, as issued by the traffic engine
    typedef struct packed {
        logic      valid;
        logic      write;
        va_t       addr;
        mem_data_t data;
    } va_req_t;

    // Translated request leaving the block toward host memory
    typedef struct packed {
        logic      valid;
        logic      write;
        pa_t       addr;
        mem_data_t data;
    } mem_req_t;

    // A request that could not be translated; only the address is kept
    typedef struct packed {
        logic valid;
        logic write;
        va_t  addr;
    } xlate_fail_t;

endpackage

// File: design/afu_csr_pkg.sv
/*
 * CSR space definitions.
 * Word-indexed CSR map, MMIO data and tag types, the test identifier,
 * and the control records sent to the engine and the page table.
 */

package afu_csr_pkg;

    // CSR indices count 64-bit words, not bytes
    typedef logic [7:0] csr_addr_t;
    typedef logic [63:0] csr_data_t;
    typedef logic [8:0] mmio_tid_t;
    // Number of requests in one engine run
    typedef logic [15:0] eng_cnt_t;

    // Unique identifier software uses to find this test
    localparam logic [127:0] TEST_ID = 128'h9dcf6fcd_3699_4979_956a_666f7cff59d6;

    // ====================
    // CSR map
    // ====================

    localparam csr_addr_t CSR_ID_LO = 8'd0;
    localparam csr_addr_t CSR_ID_HI = 8'd1;
    localparam csr_addr_t CSR_CONFIG = 8'd2;
    localparam csr_addr_t CSR_FAIL_RD_VA = 8'd3;
    localparam csr_addr_t CSR_FAIL_WR_VA = 8'd4;
    localparam csr_addr_t CSR_FAIL_CNT = 8'd5;
    localparam csr_addr_t CSR_ENG_BASE = 8'd8;
    localparam csr_addr_t CSR_ENG_CTRL = 8'd9;
    // First of PT_ENTRIES consecutive page table words
    localparam csr_addr_t CSR_PT_BASE = 8'd32;

    // Field positions inside written words
    localparam int ENG_WR_BIT = 16;
    localparam int PT_VALID_BIT = 63;

    // Engine run parameters; start is a one-cycle pulse
    typedef struct packed {
        logic              start;
        host_mem_pkg::va_t base;
        eng_cnt_t          count;
        logic              write;
    } eng_cfg_t;

    // Page table update strobe
    typedef struct packed {
        logic                  valid;
        host_mem_pkg::pt_idx_t idx;
        logic                  entry_valid;
        host_mem_pkg::ppn_t    ppn;
    } pt_wr_t;

endpackage

// File: design/afu_csr_mgr.sv
/*
 * CSR manager.
 * Decodes MMIO writes into engine configuration and page table
 * updates, and answers MMIO reads one cycle later from a registered
 * read-back multiplexer with the request tag echoed.
 */

module afu_csr_mgr
(
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   mmio_wr,
    input  logic                   mmio_rd,
    input  afu_csr_pkg::csr_addr_t mmio_addr,
    input  afu_csr_pkg::csr_data_t mmio_wdata,
    input  afu_csr_pkg::mmio_tid_t mmio_tid,
    output logic                   mmio_rd_valid,
    output afu_csr_pkg::csr_data_t mmio_rdata,
    output afu_csr_pkg::mmio_tid_t mmio_rd_tid,

    output afu_csr_pkg::eng_cfg_t  eng_cfg,
    input  logic                   eng_busy,

    output afu_csr_pkg::pt_wr_t    pt_wr,

    input  host_mem_pkg::va_t      fail_rd_va,
    input  host_mem_pkg::va_t      fail_wr_va,
    input  logic [15:0]            fail_rd_cnt,
    input  logic [15:0]            fail_wr_cnt
);

    logic                   pt_hit;
    logic                   ctrl_wr;
    afu_csr_pkg::csr_data_t rd_mux;

    // ====================
    // Write decode
    // ====================

    // Page table words sit in one aligned block starting at CSR_PT_BASE
    assign pt_hit = (mmio_addr >= afu_csr_pkg::CSR_PT_BASE) &&
                    (mmio_addr < afu_csr_pkg::CSR_PT_BASE + host_mem_pkg::PT_ENTRIES);
    assign ctrl_wr = mmio_wr && (mmio_addr == afu_csr_pkg::CSR_ENG_CTRL);

    // The table update goes out in the write cycle itself, so the entry
    // is in place at the end of that cycle
    always_comb
    begin
        pt_wr.valid = mmio_wr && pt_hit;
        pt_wr.idx = host_mem_pkg::pt_idx_t'(mmio_addr - afu_csr_pkg::CSR_PT_BASE);
        pt_wr.entry_valid = mmio_wdata[afu_csr_pkg::PT_VALID_BIT];
        pt_wr.ppn = mmio_wdata[host_mem_pkg::PPN_WIDTH-1:0];
    end

    // A control write turns into a start pulse in the following cycle
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            eng_cfg.start <= 1'b0;
        else
            eng_cfg.start <= ctrl_wr;
    end

    // Run parameters are held until the next write to the same CSR
    always_ff @(posedge clk)
    begin
        if (mmio_wr && (mmio_addr == afu_csr_pkg::CSR_ENG_BASE))
            eng_cfg.base <= mmio_wdata[host_mem_pkg::VA_WIDTH-1:0];
        if (ctrl_wr)
        begin
            eng_cfg.count <= mmio_wdata[$bits(afu_csr_pkg::eng_cnt_t)-1:0];
            eng_cfg.write <= mmio_wdata[afu_csr_pkg::ENG_WR_BIT];
        end
    end

    // ====================
    // Read back
    // ====================

    always_comb
    begin
        case (mmio_addr)
            afu_csr_pkg::CSR_ID_LO:      rd_mux = afu_csr_pkg::TEST_ID[63:0];
            afu_csr_pkg::CSR_ID_HI:      rd_mux = afu_csr_pkg::TEST_ID[127:64];
            // Table size in the low byte, page offset width above it
            afu_csr_pkg::CSR_CONFIG:     rd_mux = {48'd0, 8'(host_mem_pkg::PAGE_BITS),
                                                   8'(host_mem_pkg::PT_ENTRIES)};
            afu_csr_pkg::CSR_FAIL_RD_VA: rd_mux = 64'(fail_rd_va);
            afu_csr_pkg::CSR_FAIL_WR_VA: rd_mux = 64'(fail_wr_va);
            afu_csr_pkg::CSR_FAIL_CNT:   rd_mux = {32'd0, fail_wr_cnt, fail_rd_cnt};
            afu_csr_pkg::CSR_ENG_CTRL:   rd_mux = {63'd0, eng_busy};
            // Anything unmapped reads as zero
            default:                     rd_mux = '0;
        endcase
    end

    // Every read is answered exactly one cycle later
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            mmio_rd_valid <= 1'b0;
        else
            mmio_rd_valid <= mmio_rd;
    end

    always_ff @(posedge clk)
    begin
        mmio_rdata <= rd_mux;
        mmio_rd_tid <= mmio_tid;
    end

endmodule

// File: design/va_traffic_engine.sv
/*
 * Sequential traffic engine.
 * Issues a run of read or write requests on consecutive cache lines
 * of a virtual address range, one per cycle, after a start pulse.
 */

module va_traffic_engine
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  afu_csr_pkg::eng_cfg_t eng_cfg,
    output logic                  busy,
    output host_mem_pkg::va_req_t va_req
);

    typedef enum logic {
        ENG_IDLE,
        ENG_RUN
    } eng_state_t;

    eng_state_t            state;
    afu_csr_pkg::eng_cnt_t idx;
    afu_csr_pkg::eng_cnt_t count_q;
    host_mem_pkg::va_t     base_q;
    logic                  write_q;

    // ====================
    // Run control
    // ====================

    // A start is only taken while idle, and an empty run never leaves idle
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= ENG_IDLE;
            idx <= '0;
        end
        else
        begin
            case (state)
                ENG_IDLE:
                begin
                    idx <= '0;
                    if (eng_cfg.start && (eng_cfg.count != '0))
                        state <= ENG_RUN;
                end
                ENG_RUN:
                begin
                    idx <= idx + 1'b1;
                    // The last request goes out in this cycle
                    if (idx == count_q - 1'b1)
                        state <= ENG_IDLE;
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // Parameters are captured together with the accepted start
    always_ff @(posedge clk)
    begin
        if ((state == ENG_IDLE) && eng_cfg.start)
        begin
            base_q <= eng_cfg.base;
            count_q <= eng_cfg.count;
            write_q <= eng_cfg.write;
        end
    end

    // ====================
    // Request output
    // ====================

    assign busy = (state == ENG_RUN);

    // Request i goes to base plus i lines and carries i as its data
    always_comb
    begin
        va_req.valid = (state == ENG_RUN);
        va_req.write = write_q;
        va_req.addr = base_q + host_mem_pkg::va_t'(idx) *
                      host_mem_pkg::va_t'(host_mem_pkg::LINE_BYTES);
        va_req.data = host_mem_pkg::mem_data_t'(idx);
    end

endmodule

// File: design/vtp_translate.sv
/*
 * Virtual to physical translator.
 * Small direct-indexed page table written through CSRs, and a
 * one-cycle registered lookup that emits either the translated
 * request or a failure record, never both.
 */

module vtp_translate
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  afu_csr_pkg::pt_wr_t       pt_wr,
    input  host_mem_pkg::va_req_t     va_req,
    output host_mem_pkg::mem_req_t    mem_req,
    output host_mem_pkg::xlate_fail_t xlate_fail
);

    // Valid flags are control state, page numbers are plain storage
    logic               pt_valid [host_mem_pkg::PT_ENTRIES];
    host_mem_pkg::ppn_t pt_ppn [host_mem_pkg::PT_ENTRIES];

    host_mem_pkg::vpn_t    vpn;
    host_mem_pkg::pt_idx_t idx;
    logic                  in_range;
    logic                  hit;
    host_mem_pkg::pa_t     pa;

    // ====================
    // Page table
    // ====================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < host_mem_pkg::PT_ENTRIES; i++)
                pt_valid[i] <= 1'b0;
        end
        else if (pt_wr.valid)
        begin
            pt_valid[pt_wr.idx] <= pt_wr.entry_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pt_wr.valid)
            pt_ppn[pt_wr.idx] <= pt_wr.ppn;
    end

    // ====================
    // Lookup
    // ====================

    // Only virtual pages below PT_ENTRIES have a table slot at all
    always_comb
    begin
        vpn = va_req.addr[host_mem_pkg::VA_WIDTH-1:host_mem_pkg::PAGE_BITS];
        idx = host_mem_pkg::pt_idx_t'(vpn);
        in_range = (vpn < host_mem_pkg::vpn_t'(host_mem_pkg::PT_ENTRIES));
        hit = in_range && pt_valid[idx];
        // Physical page number joined with the untouched page offset
        pa = {pt_ppn[idx], va_req.addr[host_mem_pkg::PAGE_BITS-1:0]};
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mem_req.valid <= 1'b0;
            xlate_fail.valid <= 1'b0;
        end
        else
        begin
            mem_req.valid <= va_req.valid && hit;
            xlate_fail.valid <= va_req.valid && !hit;
        end
    end

    // A failure keeps the original virtual address for the statistics
    always_ff @(posedge clk)
    begin
        mem_req.write <= va_req.write;
        mem_req.addr <= pa;
        mem_req.data <= va_req.data;
        xlate_fail.write <= va_req.write;
        xlate_fail.addr <= va_req.addr;
    end

endmodule

// File: design/vtp_fail_stats.sv
/*
 * Translation failure recorder.
 * Keeps the last failing virtual address and a saturating count,
 * separately for reads and for writes. Failed requests end here.
 */

module vtp_fail_stats
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  host_mem_pkg::xlate_fail_t xlate_fail,
    output host_mem_pkg::va_t         fail_rd_va,
    output host_mem_pkg::va_t         fail_wr_va,
    output logic [15:0]               fail_rd_cnt,
    output logic [15:0]               fail_wr_cnt
);

    // Software reads these, so they all start from zero
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            fail_rd_va <= '0;
            fail_wr_va <= '0;
            fail_rd_cnt <= '0;
            fail_wr_cnt <= '0;
        end
        else if (xlate_fail.valid)
        begin
            if (xlate_fail.write)
            begin
                fail_wr_va <= xlate_fail.addr;
                // Counts stick at all ones rather than wrap
                if (fail_wr_cnt != '1)
                    fail_wr_cnt <= fail_wr_cnt + 1'b1;
            end
            else
            begin
                fail_rd_va <= xlate_fail.addr;
                if (fail_rd_cnt != '1)
                    fail_rd_cnt <= fail_rd_cnt + 1'b1;
            end
        end
    end

endmodule

// File: design/vtp_afu_top.sv
/*
 * Accelerator top level.
 * CSR manager, traffic engine, translator and failure recorder,
 * connected by wires only.
 */

module vtp_afu_top
(
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   mmio_wr,
    input  logic                   mmio_rd,
    input  afu_csr_pkg::csr_addr_t mmio_addr,
    input  afu_csr_pkg::csr_data_t mmio_wdata,
    input  afu_csr_pkg::mmio_tid_t mmio_tid,
    output logic                   mmio_rd_valid,
    output afu_csr_pkg::csr_data_t mmio_rdata,
    output afu_csr_pkg::mmio_tid_t mmio_rd_tid,

    output host_mem_pkg::mem_req_t mem_req
);

    afu_csr_pkg::eng_cfg_t     eng_cfg;
    logic                      eng_busy;
    afu_csr_pkg::pt_wr_t       pt_wr;
    host_mem_pkg::va_req_t     va_req;
    host_mem_pkg::xlate_fail_t xlate_fail;
    host_mem_pkg::va_t         fail_rd_va;
    host_mem_pkg::va_t         fail_wr_va;
    logic [15:0]               fail_rd_cnt;
    logic [15:0]               fail_wr_cnt;

    // Control and status registers
    afu_csr_mgr csr_mgr
    (
        .clk,
        .rst_n,
        .mmio_wr,
        .mmio_rd,
        .mmio_addr,
        .mmio_wdata,
        .mmio_tid,
        .mmio_rd_valid,
        .mmio_rdata,
        .mmio_rd_tid,
        .eng_cfg,
        .eng_busy,
        .pt_wr,
        .fail_rd_va,
        .fail_wr_va,
        .fail_rd_cnt,
        .fail_wr_cnt
    );

    va_traffic_engine eng
    (
        .clk,
        .rst_n,
        .eng_cfg,
        .busy(eng_busy),
        .va_req
    );

    // Good translations leave the block, failures go to the recorder
    vtp_translate vtp
    (
        .clk,
        .rst_n,
        .pt_wr,
        .va_req,
        .mem_req,
        .xlate_fail
    );

    vtp_fail_stats fail_stats
    (
        .clk,
        .rst_n,
        .xlate_fail,
        .fail_rd_va,
        .fail_wr_va,
        .fail_rd_cnt,
        .fail_wr_cnt
    );

endmodule

// File: sim/tb_vtp_afu.sv
/*
 * Testbench for the accelerator top level.
 * Clock and reset, LFSR stimulus over MMIO, a reference page table,
 * an engine and statistics model, concurrent checks and a watchdog.
 */

module tb_vtp_afu;

    // One expected engine request and the cycle it is issued in
    typedef struct packed {
        logic [31:0]             cyc;
        logic                    write;
        host_mem_pkg::va_t       va;
        host_mem_pkg::mem_data_t data;
    } exp_req_t;

    logic                   clk;
    logic                   rst_n;
    logic                   mmio_wr;
    logic                   mmio_rd;
    afu_csr_pkg::csr_addr_t mmio_addr;
    afu_csr_pkg::csr_data_t mmio_wdata;
    afu_csr_pkg::mmio_tid_t mmio_tid;
    logic                   mmio_rd_valid;
    afu_csr_pkg::csr_data_t mmio_rdata;
    afu_csr_pkg::mmio_tid_t mmio_rd_tid;
    host_mem_pkg::mem_req_t mem_req;

    logic [31:0]             lfsr;
    logic                    started;
    int                      budget;
    logic                    budget_ready;
    int                      counts [5];
    int                      cyc;
    int                      run_lo;
    int                      run_hi;
    exp_req_t                exp_q [$];
    logic                    ref_valid [host_mem_pkg::PT_ENTRIES];
    host_mem_pkg::ppn_t      ref_ppn [host_mem_pkg::PT_ENTRIES];
    host_mem_pkg::va_t       eng_base;
    host_mem_pkg::va_t       stat_rd_va;
    host_mem_pkg::va_t       stat_wr_va;
    logic [15:0]             stat_rd_cnt;
    logic [15:0]             stat_wr_cnt;
    logic                    exp_rd_valid;
    afu_csr_pkg::mmio_tid_t  exp_rd_tid;
    afu_csr_pkg::csr_data_t  exp_rdata;
    logic                    exp_mem_valid;
    logic                    exp_mem_write;
    host_mem_pkg::pa_t       exp_mem_addr;
    host_mem_pkg::mem_data_t exp_mem_data;
    logic                    exp_fail_valid;
    logic                    exp_fail_write;
    host_mem_pkg::va_t       exp_fail_va;

    vtp_afu_top dut
    (
        .clk,
        .rst_n,
        .mmio_wr,
        .mmio_rd,
        .mmio_addr,
        .mmio_wdata,
        .mmio_tid,
        .mmio_rd_valid,
        .mmio_rdata,
        .mmio_rd_tid,
        .mem_req
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ====================
    // Helpers
    // ====================

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h8020_0003;
        return n;
    endfunction

    // One LFSR step per bit taken, using the low bit of each new state
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic host_mem_pkg::va_t line_addr(input int page, input int line);
        return host_mem_pkg::va_t'((page << host_mem_pkg::PAGE_BITS) +
                                   line * host_mem_pkg::LINE_BYTES);
    endfunction

    function automatic logic model_busy(input int k);
        return (k >= run_lo) && (k <= run_hi);
    endfunction

    // CSR contents as software should see them in the current cycle
    function automatic afu_csr_pkg::csr_data_t expected_csr(input afu_csr_pkg::csr_addr_t a);
        afu_csr_pkg::csr_data_t v;
        v = '0;
        case (a)
            afu_csr_pkg::CSR_ID_LO:      v = afu_csr_pkg::TEST_ID[63:0];
            afu_csr_pkg::CSR_ID_HI:      v = afu_csr_pkg::TEST_ID[127:64];
            afu_csr_pkg::CSR_CONFIG:
            begin
                v[7:0] = 8'(host_mem_pkg::PT_ENTRIES);
                v[15:8] = 8'(host_mem_pkg::PAGE_BITS);
            end
            afu_csr_pkg::CSR_FAIL_RD_VA: v[47:0] = stat_rd_va;
            afu_csr_pkg::CSR_FAIL_WR_VA: v[47:0] = stat_wr_va;
            afu_csr_pkg::CSR_FAIL_CNT:   v[31:0] = {stat_wr_cnt, stat_rd_cnt};
            afu_csr_pkg::CSR_ENG_CTRL:   v[0] = model_busy(cyc);
            default:                     v = '0;
        endcase
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        $display("Simulation FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    // ====================
    // Reference model
    // ====================

    // Inputs are read before the drivers' NBAs land, as the DUT sees them
    always @(posedge clk)
    begin
        exp_req_t          req;
        host_mem_pkg::va_t page;
        logic              hit;
        int                n;
        int                slot;
        started = 1'b1;
        if (!rst_n)
        begin
            cyc = 0;
            run_lo = 1;
            run_hi = 0;
            exp_rd_valid = 1'b0;
            exp_mem_valid = 1'b0;
            exp_fail_valid = 1'b0;
            stat_rd_va = '0;
            stat_wr_va = '0;
            stat_rd_cnt = '0;
            stat_wr_cnt = '0;
            for (int i = 0; i < host_mem_pkg::PT_ENTRIES; i++)
                ref_valid[i] = 1'b0;
            exp_q.delete();
        end
        else
        begin
            // Read answered next cycle from the state of this one
            exp_rd_valid = mmio_rd;
            exp_rd_tid = mmio_tid;
            exp_rdata = expected_csr(mmio_addr);
            // A failure of this cycle reaches the statistics at its end
            if (exp_fail_valid && exp_fail_write)
            begin
                stat_wr_va = exp_fail_va;
                if (stat_wr_cnt != 16'hffff)
                    stat_wr_cnt = stat_wr_cnt + 16'd1;
            end
            else if (exp_fail_valid)
            begin
                stat_rd_va = exp_fail_va;
                if (stat_rd_cnt != 16'hffff)
                    stat_rd_cnt = stat_rd_cnt + 16'd1;
            end
            exp_mem_valid = 1'b0;
            exp_fail_valid = 1'b0;
            // Request issued now is translated with today's table
            if ((exp_q.size() != 0) && (exp_q[0].cyc == 32'(cyc)))
            begin
                req = exp_q.pop_front();
                page = req.va >> host_mem_pkg::PAGE_BITS;
                hit = (page < host_mem_pkg::PT_ENTRIES) && ref_valid[page[3:0]];
                exp_mem_valid = hit;
                exp_fail_valid = !hit;
                exp_mem_write = req.write;
                exp_mem_addr = {ref_ppn[page[3:0]], req.va[host_mem_pkg::PAGE_BITS-1:0]};
                exp_mem_data = req.data;
                exp_fail_write = req.write;
                exp_fail_va = req.va;
            end
            if (mmio_wr && (mmio_addr == afu_csr_pkg::CSR_ENG_BASE))
                eng_base = mmio_wdata[47:0];
            if (mmio_wr && (mmio_addr >= afu_csr_pkg::CSR_PT_BASE) &&
                (mmio_addr < afu_csr_pkg::CSR_PT_BASE + host_mem_pkg::PT_ENTRIES))
            begin
                slot = int'(mmio_addr - afu_csr_pkg::CSR_PT_BASE);
                ref_valid[slot] = mmio_wdata[63];
                ref_ppn[slot] = mmio_wdata[35:0];
            end
            // Start pulse lands next cycle and is dropped if the engine runs then
            n = int'(mmio_wdata[15:0]);
            if (mmio_wr && (mmio_addr == afu_csr_pkg::CSR_ENG_CTRL) &&
                !model_busy(cyc + 1) && (n != 0))
            begin
                run_lo = cyc + 2;
                run_hi = cyc + 1 + n;
                for (int i = 0; i < n; i++)
                begin
                    req.cyc = 32'(cyc + 2 + i);
                    req.write = mmio_wdata[16];
                    req.va = eng_base + host_mem_pkg::va_t'(i * host_mem_pkg::LINE_BYTES);
                    req.data = host_mem_pkg::mem_data_t'(i);
                    exp_q.push_back(req);
                end
            end
            cyc = cyc + 1;
        end
    end

    // ====================
    // Checks
    // ====================

    a_rd_valid: assert property (@(posedge clk) !started || (mmio_rd_valid == exp_rd_valid))
        else report_mismatch("mmio_rd_valid", 64'($sampled(mmio_rd_valid)),
                             64'($sampled(exp_rd_valid)));
    a_rd_tid: assert property (@(posedge clk) !exp_rd_valid || (mmio_rd_tid == exp_rd_tid))
        else report_mismatch("mmio_rd_tid", 64'($sampled(mmio_rd_tid)),
                             64'($sampled(exp_rd_tid)));
    a_rdata: assert property (@(posedge clk) !exp_rd_valid || (mmio_rdata == exp_rdata))
        else report_mismatch("mmio_rdata", $sampled(mmio_rdata), $sampled(exp_rdata));
    a_mem_valid: assert property (@(posedge clk) !started || (mem_req.valid == exp_mem_valid))
        else report_mismatch("mem_req.valid", 64'($sampled(mem_req.valid)),
                             64'($sampled(exp_mem_valid)));
    a_mem_write: assert property (@(posedge clk) !exp_mem_valid || (mem_req.write == exp_mem_write))
        else report_mismatch("mem_req.write", 64'($sampled(mem_req.write)),
                             64'($sampled(exp_mem_write)));
    a_mem_addr: assert property (@(posedge clk) !exp_mem_valid || (mem_req.addr == exp_mem_addr))
        else report_mismatch("mem_req.addr", 64'($sampled(mem_req.addr)),
                             64'($sampled(exp_mem_addr)));
    a_mem_data: assert property (@(posedge clk) !exp_mem_valid || (mem_req.data == exp_mem_data))
        else report_mismatch("mem_req.data", $sampled(mem_req.data), $sampled(exp_mem_data));

    // ====================
    // Stimulus
    // ====================

    task automatic csr_write(input afu_csr_pkg::csr_addr_t a, input afu_csr_pkg::csr_data_t d);
        @(posedge clk);
        mmio_wr <= 1'b1;
        mmio_addr <= a;
        mmio_wdata <= d;
        @(posedge clk);
        mmio_wr <= 1'b0;
    endtask

    // Read data is taken at the falling edge after the response cycle
    task automatic csr_read(input afu_csr_pkg::csr_addr_t a, output afu_csr_pkg::csr_data_t d);
        @(posedge clk);
        mmio_rd <= 1'b1;
        mmio_addr <= a;
        mmio_tid <= afu_csr_pkg::mmio_tid_t'(take_bits(9));
        @(posedge clk);
        mmio_rd <= 1'b0;
        @(negedge clk);
        d = mmio_rdata;
    endtask

    task automatic start_run(input host_mem_pkg::va_t base, input int count, input logic write);
        afu_csr_pkg::csr_data_t w;
        w = '0;
        w[15:0] = 16'(count);
        w[16] = write;
        csr_write(afu_csr_pkg::CSR_ENG_BASE, 64'(base));
        csr_write(afu_csr_pkg::CSR_ENG_CTRL, w);
    endtask

    // Poll the busy bit, then let the last translation drain
    task automatic wait_run_done();
        afu_csr_pkg::csr_data_t status;
        status = 64'd1;
        while (status[0])
            csr_read(afu_csr_pkg::CSR_ENG_CTRL, status);
        while ((exp_q.size() != 0) || exp_mem_valid || exp_fail_valid)
            @(negedge clk);
    endtask

    // Budget grows with the requested work of all runs
    initial
    begin
        wait (budget_ready);
        #(4 * budget + 2000);
        abort_run("Watchdog expired before the engine runs completed");
    end

    initial
    begin
        afu_csr_pkg::csr_data_t rd;
        int                     bad_page;
        int                     page;
        int                     line;
        rst_n = 1'b0;
        mmio_wr = 1'b0;
        mmio_rd = 1'b0;
        mmio_addr = '0;
        mmio_wdata = '0;
        mmio_tid = '0;
        started = 1'b0;
        exp_rd_valid = 1'b0;
        exp_mem_valid = 1'b0;
        budget_ready = 1'b0;
        lfsr = 32'hf050;
        budget = 0;
        for (int i = 0; i < 5; i++)
        begin
            counts[i] = 8 + int'(take_bits(5));
            budget = budget + counts[i];
        end
        // The restart write repeats the last count
        budget = budget + counts[4];
        budget_ready = 1'b1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Identifier, configuration, idle status and an unmapped word
        csr_read(afu_csr_pkg::CSR_ID_LO, rd);
        csr_read(afu_csr_pkg::CSR_ID_HI, rd);
        csr_read(afu_csr_pkg::CSR_CONFIG, rd);
        csr_read(afu_csr_pkg::CSR_ENG_CTRL, rd);
        csr_read(8'd6, rd);
        csr_read(afu_csr_pkg::CSR_FAIL_CNT, rd);

        // Every page valid with a random frame
        for (int i = 0; i < host_mem_pkg::PT_ENTRIES; i++)
            csr_write(afu_csr_pkg::csr_addr_t'(afu_csr_pkg::CSR_PT_BASE + i),
                      {1'b1, 27'd0, host_mem_pkg::ppn_t'(take_bits(36))});

        // Reads, then writes, over mapped pages
        page = int'(take_bits(4)) % 14;
        line = int'(take_bits(6));
        start_run(line_addr(page, line), counts[0], 1'b0);
        wait_run_done();
        page = int'(take_bits(4)) % 14;
        line = int'(take_bits(6));
        start_run(line_addr(page, line), counts[1], 1'b1);
        wait_run_done();

        // Reads running off the end of the table
        start_run(line_addr(15, 59), counts[2], 1'b0);
        wait_run_done();
        // Writes running into an unmapped page
        bad_page = 1 + int'(take_bits(4)) % 13;
        csr_write(afu_csr_pkg::csr_addr_t'(afu_csr_pkg::CSR_PT_BASE + bad_page), 64'd0);
        start_run(line_addr(bad_page - 1, 60), counts[3], 1'b1);
        wait_run_done();
        csr_read(afu_csr_pkg::CSR_FAIL_RD_VA, rd);
        csr_read(afu_csr_pkg::CSR_FAIL_WR_VA, rd);
        csr_read(afu_csr_pkg::CSR_FAIL_CNT, rd);

        // A second start during a run, and a status read while busy
        start_run(line_addr(2, 0), counts[4], 1'b0);
        csr_write(afu_csr_pkg::CSR_ENG_CTRL, 64'(counts[4]));
        csr_read(afu_csr_pkg::CSR_ENG_CTRL, rd);
        wait_run_done();

        // Empty run must stay quiet
        start_run(line_addr(4, 0), 0, 1'b1);
        wait_run_done();
        repeat (8) @(posedge clk);
        csr_read(afu_csr_pkg::CSR_FAIL_CNT, rd);
        @(negedge clk);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: vtp_afu.f
design/host_mem_pkg.sv
design/afu_csr_pkg.sv
design/afu_csr_mgr.sv
design/va_traffic_engine.sv
design/vtp_translate.sv
design/vtp_fail_stats.sv
design/vtp_afu_top.sv
sim/tb_vtp_afu.sv

// File: Makefile
# Verilator flow for the VTP accelerator testbench

VERILATOR    ?= verilator
TOP          ?= tb_vtp_afu
RTL_TOP      ?= vtp_afu_top
FILELIST     ?= vtp_afu.f
BUILD_DIR    ?= obj_dir
LOG          ?= sim.log
PASS_PATTERN ?= Simulation PASSED
LINT_FLAGS   ?= --lint-only --timing --assert
BUILD_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint lint_rtl build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

lint_rtl:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		design/host_mem_pkg.sv design/afu_csr_pkg.sv design/afu_csr_mgr.sv \
		design/va_traffic_engine.sv design/vtp_translate.sv \
		design/vtp_fail_stats.sv design/vtp_afu_top.sv

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-o V$(TOP) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_PATTERN)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
